// File: tb.f
+incdir+.
iob_apb_pkg.sv
apb_wait_timer.sv
apb_regfile.sv
iob2apb_fsm.sv
iob_apb_top.sv
iob_apb_sva.sv
iob_apb_tb.sv

// File: Makefile
TOOL       = verilator
TOP        = iob_apb_tb
FILELIST   = tb.f
LINT_FLAGS = --lint-only -Wall --timing --assert
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = All tests passed!

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only if the log holds the pass line
sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q '$(PASS_MSG)' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: iob_apb_tb.sv
`timescale 1ns/1ps
`include "iob_apb_macros.svh"

module iob_apb_tb;

   import iob_apb_pkg::*;

   typedef logic [`IOB_APB_ADDR_W-1:0] addr_t;
   typedef logic [`IOB_APB_DATA_W-1:0] data_t;
   typedef logic [`IOB_APB_STRB_W-1:0] strb_t;

   localparam int CLK_PERIOD = 100;
   localparam int MAX_LAT    = 12;                   // Worst legal case is 6
   localparam int BANK_BYTES = `IOB_APB_NREGS * 4;
   localparam int N_WORD     = 16;
   localparam int N_STRB     = 24;
   localparam int N_OOR      = 8;
   localparam int N_MIX      = 200;
   localparam int N_XFERS    = 2 * `IOB_APB_NREGS + 2 * N_WORD + 2 * N_STRB
                               + 2 * N_OOR + `IOB_APB_NREGS + 8 + N_MIX;
   localparam int WATCHDOG_CYCLES = N_XFERS * 8 + 100;

   logic      clk;
   logic      rst_n;
   iob_req_t  iob_req;
   iob_resp_t iob_resp;

   data_t  model [`IOB_APB_NREGS];  // Expected register contents
   integer seed;
   int     errors;
   int     checks;
   int     tests_failed;

   iob_apb_top iob_apb_top_i (
      .clk_i      (clk),
      .rst_n_i    (rst_n),
      .iob_req_i  (iob_req),
      .iob_resp_o (iob_resp)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Run timed out after %0d cycles before all tests completed", WATCHDOG_CYCLES);
      $display("Test failures found");
      $finish;
   end

   task automatic check_value(input string what, input data_t got, input data_t exp);
      checks++;
      if (got !== exp) begin
         $display("error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   // Bank covers byte addresses 0 to 63, the rest reads zero
   function automatic data_t model_read(input addr_t addr);
      if (int'(addr) < BANK_BYTES) begin
         return model[addr[2 +: `IOB_APB_IDX_W]];
      end
      return '0;
   endfunction

   task automatic model_write(input addr_t addr, input data_t data, input strb_t strb);
      if (int'(addr) < BANK_BYTES) begin
         for (int b = 0; b < `IOB_APB_STRB_W; b++) begin
            if (strb[b]) begin
               model[addr[2 +: `IOB_APB_IDX_W]][8*b +: 8] = data[8*b +: 8];
            end
         end
      end
   endtask

   function automatic addr_t rand_bank_addr();
      data_t r;
      r = $random(seed);
      return {2'b00, r[5:2], 2'b00};
   endfunction

   // One IOb request through the bridge, checks timing and returns rdata
   task automatic iob_xfer(input addr_t addr, input data_t wdata, input strb_t wstrb,
                           output data_t rdata);
      int lat;
      bit got_rvalid;
      lat = 0;
      got_rvalid = 1'b0;
      rdata = '0;
      @(posedge clk);
      iob_req.valid <= 1'b1;
      iob_req.addr  <= addr;
      iob_req.wdata <= wdata;
      iob_req.wstrb <= wstrb;
      @(negedge clk);
      while (!iob_resp.ready) begin
         @(negedge clk);
      end
      @(posedge clk);            // Acceptance edge
      iob_req.valid <= 1'b0;
      while (!got_rvalid && lat < MAX_LAT) begin
         @(negedge clk);
         lat++;
         if (iob_resp.rvalid) begin
            got_rvalid = 1'b1;
            rdata = iob_resp.rdata;
            check_value("ready with rvalid", data_t'(iob_resp.ready), 32'd1);
         end else begin
            check_value("ready while busy", data_t'(iob_resp.ready), 32'd0);
         end
      end
      if (!got_rvalid) begin
         $display("Transfer to address %h got no rvalid within %0d cycles", addr, MAX_LAT);
         errors++;
      end else begin
         // Setup, first access and response cycles plus the wait states
         check_value("latency", data_t'(lat), data_t'(3 + int'(addr[3:2])));
      end
   endtask

   task automatic write_word(input addr_t addr, input data_t data, input strb_t strb);
      data_t rd;
      iob_xfer(addr, data, strb, rd);
      model_write(addr, data, strb);
   endtask

   task automatic read_check(input addr_t addr);
      data_t rd;
      iob_xfer(addr, '0, '0, rd);
      check_value($sformatf("read of %h", addr), rd, model_read(addr));
   endtask

   task automatic end_test(input string name, input int errs_before);
      if (errors == errs_before) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, errors - errs_before);
         tests_failed++;
      end
   endtask

   initial begin
      addr_t a;
      data_t r;
      strb_t s;
      int    e0;
      seed = 62;
      errors = 0;
      checks = 0;
      tests_failed = 0;
      iob_req = '0;
      rst_n = 1'b0;
      for (int i = 0; i < `IOB_APB_NREGS; i++) begin
         model[i] = '0;
      end
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;

      e0 = errors;
      @(negedge clk);
      check_value("ready after reset", data_t'(iob_resp.ready), 32'd1);
      check_value("rvalid after reset", data_t'(iob_resp.rvalid), 32'd0);
      for (int i = 0; i < `IOB_APB_NREGS; i++) begin
         read_check(addr_t'(4 * i));
      end
      end_test("reset values", e0);

      e0 = errors;
      for (int i = 0; i < N_WORD; i++) begin
         a = rand_bank_addr();
         write_word(a, $random(seed), 4'hF);
         read_check(a);
      end
      end_test("full word write", e0);

      e0 = errors;
      for (int i = 0; i < N_STRB; i++) begin
         a = rand_bank_addr();
         r = $random(seed);
         s = r[3:0];
         if (s == 4'h0 || s == 4'hF) begin
            s = 4'h5;                    // Keep it a partial write
         end
         write_word(a, $random(seed), s);
         read_check(a);
      end
      end_test("byte strobes", e0);

      e0 = errors;
      for (int i = 0; i < 2 * N_OOR; i++) begin
         r = $random(seed);
         a = {((r[7:6] == 2'b00) ? 2'b01 : r[7:6]), r[5:2], 2'b00};
         if (i < N_OOR) begin
            write_word(a, $random(seed), 4'hF);
         end else begin
            read_check(a);
         end
      end
      for (int i = 0; i < `IOB_APB_NREGS; i++) begin
         read_check(addr_t'(4 * i));     // Bank untouched by the writes above
      end
      end_test("out of range", e0);

      e0 = errors;
      for (int w = 0; w < 4; w++) begin
         a = rand_bank_addr();
         a[3:2] = 2'(w);
         write_word(a, $random(seed), 4'hF);
         read_check(a);
      end
      end_test("wait state latency", e0);

      e0 = errors;
      for (int i = 0; i < N_MIX; i++) begin
         r = $random(seed);
         a = {((r[9:8] == 2'b00) ? r[7:6] : 2'b00), r[5:2], 2'b00};
         s = r[13:10];                   // Zero strobes give a read
         if (s == '0) begin
            read_check(a);
         end else begin
            write_word(a, $random(seed), s);
         end
      end
      end_test("random mix", e0);

      // Protocol assertions in the bound checker
      errors += iob_apb_top_i.iob2apb_fsm_i.iob_apb_sva_i.fail_cnt;

      $display("Summary: %0d checks, %0d errors, %0d of 6 tests failed",
               checks, errors, tests_failed);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// File: iob_apb_sva.sv
`timescale 1ns/1ps

module iob_apb_sva (
   input logic                   clk_i,
   input logic                   rst_n_i,
   input iob_apb_pkg::iob_resp_t iob_resp_i,
   input iob_apb_pkg::apb_req_t  apb_req_i
);

   int unsigned fail_cnt = 0;  // Number of failed assertions

   // penable only rides on an active psel
   a_penable_psel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      apb_req_i.penable |-> apb_req_i.psel)
      else begin
         $error("APB penable high while psel low");
         fail_cnt++;
      end

   // Setup phase lasts exactly one cycle
   a_setup_len: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (apb_req_i.psel && !apb_req_i.penable) |=> (apb_req_i.psel && apb_req_i.penable))
      else begin
         $error("APB setup phase not followed by access");
         fail_cnt++;
      end

   a_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      apb_req_i.penable |-> ($stable(apb_req_i.paddr) && $stable(apb_req_i.pwrite)))
      else begin
         $error("APB paddr or pwrite changed during transfer");
         fail_cnt++;
      end

   a_data_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      apb_req_i.penable |-> ($stable(apb_req_i.pwdata) && $stable(apb_req_i.pstrb)))
      else begin
         $error("APB pwdata or pstrb changed during transfer");
         fail_cnt++;
      end

   a_rvalid_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      iob_resp_i.rvalid |=> !iob_resp_i.rvalid)
      else begin
         $error("IOb rvalid held for more than one cycle");
         fail_cnt++;
      end

endmodule

bind iob2apb_fsm iob_apb_sva iob_apb_sva_i (
   .clk_i      (clk_i),
   .rst_n_i    (rst_n_i),
   .iob_resp_i (iob_resp_o),
   .apb_req_i  (apb_req_o)
);

// File: iob_apb_top.sv
`timescale 1ns/1ps

module iob_apb_top (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  iob_apb_pkg::iob_req_t  iob_req_i,
   output iob_apb_pkg::iob_resp_t iob_resp_o
);

   import iob_apb_pkg::*;

   // Single APB segment, no decode needed
   apb_req_t  apb_req;
   apb_resp_t apb_resp;

   iob2apb_fsm iob2apb_fsm_i (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .iob_req_i  (iob_req_i),
      .iob_resp_o (iob_resp_o),
      .apb_req_o  (apb_req),
      .apb_resp_i (apb_resp)
   );

   apb_regfile apb_regfile_i (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .apb_req_i  (apb_req),
      .apb_resp_o (apb_resp)
   );

endmodule

// File: iob2apb_fsm.sv
`timescale 1ns/1ps
`include "iob_apb_macros.svh"

module iob2apb_fsm (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  iob_apb_pkg::iob_req_t  iob_req_i,
   output iob_apb_pkg::iob_resp_t iob_resp_o,
   output iob_apb_pkg::apb_req_t  apb_req_o,
   input  iob_apb_pkg::apb_resp_t apb_resp_i
);

   import iob_apb_pkg::*;

   bridge_state_t state_q, state_nxt;

   // Control registers
   logic psel_q, psel_nxt;
   logic penable_q, penable_nxt;
   logic pwrite_q, pwrite_nxt;
   logic ready_q, ready_nxt;
   logic rvalid_q, rvalid_nxt;

   // Transfer payload, only meaningful while psel or rvalid is high
   logic [`IOB_APB_ADDR_W-1:0] paddr_q, paddr_nxt;
   logic [`IOB_APB_DATA_W-1:0] pwdata_q, pwdata_nxt;
   logic [`IOB_APB_STRB_W-1:0] pstrb_q, pstrb_nxt;
   logic [`IOB_APB_DATA_W-1:0] rdata_q, rdata_nxt;

   logic accept;

   assign accept = iob_req_i.valid && ready_q;  // Handshake on the IOb side

   always_comb begin
      state_nxt   = state_q;
      psel_nxt    = psel_q;
      penable_nxt = penable_q;
      pwrite_nxt  = pwrite_q;
      ready_nxt   = ready_q;
      rvalid_nxt  = 1'b0;  // Pulse only
      paddr_nxt   = paddr_q;
      pwdata_nxt  = pwdata_q;
      pstrb_nxt   = pstrb_q;
      rdata_nxt   = rdata_q;

      case (state_q)
         ST_IDLE: begin
            if (accept) begin
               // Latch the request and open the setup phase
               paddr_nxt  = iob_req_i.addr;
               pwdata_nxt = iob_req_i.wdata;
               pstrb_nxt  = iob_req_i.wstrb;
               pwrite_nxt = (iob_req_i.wstrb != '0);
               psel_nxt   = 1'b1;
               ready_nxt  = 1'b0;
               state_nxt  = ST_SETUP;
            end
         end
         ST_SETUP: begin
            penable_nxt = 1'b1;
            state_nxt   = ST_ACCESS;
         end
         ST_ACCESS: begin
            if (apb_resp_i.pready) begin
               rdata_nxt   = apb_resp_i.prdata;  // Sampled on reads and writes alike
               rvalid_nxt  = 1'b1;
               ready_nxt   = 1'b1;
               psel_nxt    = 1'b0;
               penable_nxt = 1'b0;
               state_nxt   = ST_IDLE;
            end
         end
         default: begin
            state_nxt = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q   <= ST_IDLE;
         psel_q    <= 1'b0;
         penable_q <= 1'b0;
         pwrite_q  <= 1'b0;
         ready_q   <= 1'b1;  // Ready straight out of reset
         rvalid_q  <= 1'b0;
      end else begin
         state_q   <= state_nxt;
         psel_q    <= psel_nxt;
         penable_q <= penable_nxt;
         pwrite_q  <= pwrite_nxt;
         ready_q   <= ready_nxt;
         rvalid_q  <= rvalid_nxt;
      end
   end

   always_ff @(posedge clk_i) begin
      paddr_q  <= paddr_nxt;
      pwdata_q <= pwdata_nxt;
      pstrb_q  <= pstrb_nxt;
      rdata_q  <= rdata_nxt;
   end

   // All outputs come straight from flops
   assign apb_req_o = '{
      psel:    psel_q,
      penable: penable_q,
      pwrite:  pwrite_q,
      paddr:   paddr_q,
      pwdata:  pwdata_q,
      pstrb:   pstrb_q
   };

   assign iob_resp_o = '{
      ready:  ready_q,
      rvalid: rvalid_q,
      rdata:  rdata_q
   };

endmodule

// File: apb_regfile.sv
`timescale 1ns/1ps
`include "iob_apb_macros.svh"

module apb_regfile (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  iob_apb_pkg::apb_req_t  apb_req_i,
   output iob_apb_pkg::apb_resp_t apb_resp_o
);

   logic [`IOB_APB_DATA_W-1:0] regs_q [`IOB_APB_NREGS];

   logic [`IOB_APB_IDX_W-1:0]  idx;       // Word index into the bank
   logic                      in_range;
   logic                      timer_start;
   logic                      timer_run;
   logic                      timer_done;
   logic                      wr_en;
   logic [`IOB_APB_DATA_W-1:0] rd_data;

   assign idx = apb_req_i.paddr[2 +: `IOB_APB_IDX_W];

   // Anything above the last word reads zero and drops writes
   assign in_range =
      (apb_req_i.paddr[`IOB_APB_ADDR_W-1:`IOB_APB_IDX_W+2] == '0);

   assign timer_start = apb_req_i.psel && !apb_req_i.penable;
   assign timer_run   = apb_req_i.psel && apb_req_i.penable;

   // Wait states follow word-address bits [3:2]
   apb_wait_timer wait_timer_i (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .start_i    (timer_start),
      .wait_cnt_i (apb_req_i.paddr[2 +: `IOB_APB_WAIT_W]),
      .run_i      (timer_run),
      .done_o     (timer_done)
   );

   // Commit on the last access cycle only
   assign wr_en = timer_run && apb_req_i.pwrite && timer_done && in_range;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < `IOB_APB_NREGS; i++) begin
            regs_q[i] <= '0;
         end
      end else if (wr_en) begin
         for (int b = 0; b < `IOB_APB_STRB_W; b++) begin
            if (apb_req_i.pstrb[b]) begin
               regs_q[idx][8*b +: 8] <= apb_req_i.pwdata[8*b +: 8];  // Byte lane merge
            end
         end
      end
   end

   assign rd_data = in_range ? regs_q[idx] : '0;

   always_comb begin
      apb_resp_o.pready = timer_done;
      apb_resp_o.prdata = rd_data;  // Valid whenever pready is high
   end

endmodule

// File: apb_wait_timer.sv
`timescale 1ns/1ps
`include "iob_apb_macros.svh"

module apb_wait_timer (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  logic                      start_i,     // Setup cycle strobe
   input  logic [`IOB_APB_WAIT_W-1:0] wait_cnt_i,  // Wait states for this access
   input  logic                      run_i,       // Access phase in progress
   output logic                      done_o
);

   logic [`IOB_APB_WAIT_W-1:0] cnt_q;
   logic                      cnt_zero;

   assign cnt_zero = (cnt_q == '0);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         cnt_q <= '0;
      end else if (start_i) begin
         cnt_q <= wait_cnt_i;  // Reload once per transfer
      end else if (run_i && !cnt_zero) begin
         cnt_q <= cnt_q - 1'b1;
      end
   end

   // Zero wait states finish in the first access cycle
   assign done_o = run_i && cnt_zero;

endmodule

// File: iob_apb_pkg.sv
`include "iob_apb_macros.svh"

package iob_apb_pkg;

   // CPU-side request, wstrb of zero means read
   typedef struct packed {
      logic                         valid;
      logic [`IOB_APB_ADDR_W-1:0]   addr;
      logic [`IOB_APB_DATA_W-1:0]   wdata;
      logic [`IOB_APB_STRB_W-1:0]   wstrb;
   } iob_req_t;

   typedef struct packed {
      logic                         ready;   // Bridge can take a request
      logic                         rvalid;  // One-cycle completion pulse
      logic [`IOB_APB_DATA_W-1:0]   rdata;
   } iob_resp_t;

   // APB master outputs
   typedef struct packed {
      logic                         psel;
      logic                         penable;
      logic                         pwrite;
      logic [`IOB_APB_ADDR_W-1:0]   paddr;
      logic [`IOB_APB_DATA_W-1:0]   pwdata;
      logic [`IOB_APB_STRB_W-1:0]   pstrb;
   } apb_req_t;

   typedef struct packed {
      logic                         pready;
      logic [`IOB_APB_DATA_W-1:0]   prdata;
   } apb_resp_t;

   typedef enum logic [1:0] {
      ST_IDLE   = 2'd0,  // Waiting for an IOb request
      ST_SETUP  = 2'd1,  // psel high, penable low
      ST_ACCESS = 2'd2   // penable high until pready
   } bridge_state_t;

endpackage

// File: iob_apb_macros.svh
`ifndef IOB_APB_MACROS_SVH
`define IOB_APB_MACROS_SVH

// Byte address width on both the IOb and APB sides
`define IOB_APB_ADDR_W 8

`define IOB_APB_DATA_W 32                     // Data bus width
`define IOB_APB_STRB_W (`IOB_APB_DATA_W / 8)  // One strobe per byte lane

// Register bank size and its word index width
`define IOB_APB_NREGS 16
`define IOB_APB_IDX_W 4

// Wait-state counter width, 0 to 3 wait states
`define IOB_APB_WAIT_W 2

`endif
